/* hdl/mips_defs.svh */
/* Widths, opcodes and the reset PC of the MIPS32 subset core.
   Only word accesses exist. Bus addresses are word indices. */
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

`define XLEN        32
`define REG_AW      5
`define RESET_PC    32'h0000_0000  // Byte address of word 0.

// Primary opcodes, instr[31:26].
`define OP_RTYPE    6'b000000
`define OP_ADDIU    6'b001001
`define OP_LUI      6'b001111
`define OP_LW       6'b100011
`define OP_SW       6'b101011
`define OP_BEQ      6'b000100
`define OP_BNE      6'b000101

// R-type function codes, instr[5:0].
`define FN_ADDU     6'b100001
`define FN_SUBU     6'b100011
`define FN_AND      6'b100100
`define FN_OR       6'b100101
`define FN_SLT      6'b101010

`endif

/* hdl/mips_pkg.sv */
/* Types shared by the core and its testbench.
   Addresses in mem_req_t and ls_req_t are word indices, PCs are byte addresses. */
`include "mips_defs.svh"

package mips_pkg;

    // One request on the shared memory bus.
    typedef struct packed {
        logic             en;
        logic             we;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] instr;
    } fetch_t;

    // Load or store order from execute.
    typedef struct packed {
        logic             we;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] wdata;
    } ls_req_t;

    // Retire record. wdata is zero when wen is low.
    typedef struct packed {
        logic [`XLEN-1:0]   pc;
        logic               wen;
        logic [`REG_AW-1:0] wraddr;
        logic [`XLEN-1:0]   wdata;
    } wb_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

endpackage

/* hdl/bus_arbiter.sv */
/* Fixed priority, load/store over fetch. Assumes memory answers reads one
   cycle after the request and never stalls, so one read is outstanding at most. */
`timescale 1ns/1ps
`include "mips_defs.svh"

module bus_arbiter
    import mips_pkg::*;
(
    input  logic             clk,
    input  logic             rst_i,
    input  mem_req_t         fetch_req_i,
    input  mem_req_t         lsu_req_i,
    output mem_req_t         mem_req_o,
    input  logic [`XLEN-1:0] mem_rdata_i,
    output logic             fetch_gnt_o,
    output logic             fetch_rvalid_o,
    output logic             lsu_rvalid_o,
    output logic [`XLEN-1:0] rdata_o
);

    logic rd_pend_q;
    logic rd_lsu_q;

    // Load/store always wins the bus.
    assign mem_req_o   = lsu_req_i.en ? lsu_req_i : fetch_req_i;
    assign fetch_gnt_o = fetch_req_i.en && !lsu_req_i.en;

    // Owner of the read granted last cycle.
    always_ff @(posedge clk) begin
        if (rst_i) begin
            rd_pend_q <= 1'b0;
            rd_lsu_q  <= 1'b0;
        end else begin
            rd_pend_q <= mem_req_o.en && !mem_req_o.we;
            rd_lsu_q  <= lsu_req_i.en;
        end
    end

    assign fetch_rvalid_o = rd_pend_q && !rd_lsu_q;
    assign lsu_rvalid_o   = rd_pend_q && rd_lsu_q;
    assign rdata_o        = mem_rdata_i;  // Shared, qualified by the rvalids.

endmodule

/* hdl/fetch_unit.sv */
/* One-entry prefetch buffer with bypass of the arriving response.
   A response that arrives together with a redirect is dropped as stale. */
`timescale 1ns/1ps
`include "mips_defs.svh"

module fetch_unit
    import mips_pkg::*;
(
    input  logic             clk,
    input  logic             rst_i,
    output mem_req_t         bus_req_o,
    input  logic             bus_gnt_i,
    input  logic             bus_rvalid_i,
    input  logic [`XLEN-1:0] bus_rdata_i,
    input  logic             redirect_i,
    input  logic [`XLEN-1:0] redirect_pc_i,
    input  logic             take_i,
    output fetch_t           inst_o,
    output logic             inst_valid_o
);

    logic [`XLEN-1:0] pc_q;
    logic [`XLEN-1:0] resp_pc_q;
    logic [`XLEN-1:0] fetch_pc;
    fetch_t           resp;
    fetch_t           buf_q;
    logic             buf_valid_q;
    logic             buf_fill;
    logic             buf_next_valid;
    logic             req_en;

    assign fetch_pc = redirect_i ? redirect_pc_i : pc_q;
    assign resp     = '{pc: resp_pc_q, instr: bus_rdata_i};

    // Response goes to the buffer unless it is taken straight away.
    assign buf_fill       = bus_rvalid_i && !redirect_i && (buf_valid_q || !take_i);
    assign buf_next_valid = buf_fill || (buf_valid_q && !take_i);

    // Ask for the next word only if the buffer ends this cycle empty.
    assign req_en    = !buf_next_valid;
    assign bus_req_o = '{en: req_en, we: 1'b0,
                         addr: {2'b00, fetch_pc[`XLEN-1:2]}, wdata: '0};

    assign inst_o       = buf_valid_q ? buf_q : resp;
    assign inst_valid_o = buf_valid_q || bus_rvalid_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q        <= `RESET_PC;
            buf_valid_q <= 1'b0;
        end else begin
            if (req_en && bus_gnt_i)
                pc_q <= fetch_pc + `XLEN'd4;
            else if (redirect_i)
                pc_q <= redirect_pc_i;  // Held request restarts at the target.
            buf_valid_q <= buf_next_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_en && bus_gnt_i)
            resp_pc_q <= fetch_pc;
        if (buf_fill)
            buf_q <= resp;
    end

endmodule

/* hdl/reg_file.sv */
/* 32 x 32 register file, two asynchronous reads, one synchronous write.
   No reset, contents are undefined until written. */
`timescale 1ns/1ps
`include "mips_defs.svh"

module reg_file (
    input  logic               clk,
    input  logic [`REG_AW-1:0] rs_addr_i,
    input  logic [`REG_AW-1:0] rt_addr_i,
    output logic [`XLEN-1:0]   rs_data_o,
    output logic [`XLEN-1:0]   rt_data_o,
    input  logic               wen_i,
    input  logic [`REG_AW-1:0] waddr_i,
    input  logic [`XLEN-1:0]   wdata_i
);

    logic [`XLEN-1:0] regs_q [1:31];  // Register 0 has no storage.

    always_ff @(posedge clk) begin
        if (wen_i && (waddr_i != '0))
            regs_q[waddr_i] <= wdata_i;
    end

    assign rs_data_o = (rs_addr_i == '0) ? '0 : regs_q[rs_addr_i];
    assign rt_data_o = (rt_addr_i == '0) ? '0 : regs_q[rt_addr_i];

endmodule

/* hdl/decode_execute.sv */
/* Single-cycle decode and execute, in order, one instruction at a time.
   No delay slots. Unknown opcodes and functions retire with wen low. */
`timescale 1ns/1ps
`include "mips_defs.svh"

module decode_execute
    import mips_pkg::*;
(
    input  logic             clk,
    input  logic             rst_i,
    input  fetch_t           inst_i,
    input  logic             inst_valid_i,
    output logic             take_o,
    output logic             redirect_o,
    output logic [`XLEN-1:0] redirect_pc_o,
    output logic             ls_go_o,
    output ls_req_t          ls_req_o,
    input  logic             ls_done_i,
    input  logic [`XLEN-1:0] ls_rdata_i,
    output wb_t              wb_o,
    output logic             wb_valid_o
);

    logic [5:0]         opcode;
    logic [5:0]         funct;
    logic [`REG_AW-1:0] rs;
    logic [`REG_AW-1:0] rt;
    logic [`REG_AW-1:0] rd;
    logic [`XLEN-1:0]   simm;
    logic [`XLEN-1:0]   rs_data;
    logic [`XLEN-1:0]   rt_data;
    logic [`XLEN-1:0]   opb;
    logic [`XLEN-1:0]   alu_res;
    logic [`XLEN-1:0]   mem_addr;
    alu_op_e            alu_op;
    logic               is_mem;
    logic               br_taken;
    logic               busy_q;
    logic               retire;
    logic               wb_valid_q;
    wb_t                cur_rec;
    wb_t                pend_q;
    wb_t                ret_rec;
    wb_t                wb_q;

    assign opcode = inst_i.instr[31:26];
    assign rs     = inst_i.instr[25:21];
    assign rt     = inst_i.instr[20:16];
    assign rd     = inst_i.instr[15:11];
    assign funct  = inst_i.instr[5:0];
    assign simm   = {{16{inst_i.instr[15]}}, inst_i.instr[15:0]};

    reg_file u_reg_file (
        .clk       (clk                   ),
        .rs_addr_i (rs                    ),
        .rt_addr_i (rt                    ),
        .rs_data_o (rs_data               ),
        .rt_data_o (rt_data               ),
        .wen_i     (retire && ret_rec.wen ),
        .waddr_i   (ret_rec.wraddr        ),
        .wdata_i   (ret_rec.wdata         )
    );

    always_comb begin
        alu_op   = ALU_ADD;
        opb      = simm;
        cur_rec  = '{pc: inst_i.pc, wen: 1'b0, wraddr: rt, wdata: '0};
        is_mem   = 1'b0;
        br_taken = 1'b0;
        case (opcode)
            `OP_RTYPE: begin
                opb            = rt_data;
                cur_rec.wraddr = rd;
                cur_rec.wen    = 1'b1;
                case (funct)
                    `FN_ADDU: alu_op = ALU_ADD;
                    `FN_SUBU: alu_op = ALU_SUB;
                    `FN_AND:  alu_op = ALU_AND;
                    `FN_OR:   alu_op = ALU_OR;
                    `FN_SLT:  alu_op = ALU_SLT;
                    default:  cur_rec.wen = 1'b0;
                endcase
            end
            `OP_ADDIU: cur_rec.wen = 1'b1;
            `OP_LUI: begin
                alu_op      = ALU_LUI;
                cur_rec.wen = 1'b1;
            end
            `OP_LW: begin
                is_mem      = 1'b1;
                cur_rec.wen = 1'b1;  // Data arrives with ls_done.
            end
            `OP_SW:  is_mem = 1'b1;
            `OP_BEQ: br_taken = (rs_data == rt_data);
            `OP_BNE: br_taken = (rs_data != rt_data);
            default: ;
        endcase
    end

    always_comb begin
        case (alu_op)
            ALU_SUB: alu_res = rs_data - opb;
            ALU_AND: alu_res = rs_data & opb;
            ALU_OR:  alu_res = rs_data | opb;
            ALU_SLT: alu_res = {31'd0, $signed(rs_data) < $signed(opb)};
            ALU_LUI: alu_res = {simm[15:0], 16'h0000};
            default: alu_res = rs_data + opb;
        endcase
    end

    assign take_o        = inst_valid_i && !busy_q;
    assign redirect_o    = take_o && br_taken;
    assign redirect_pc_o = inst_i.pc + `XLEN'd4 + {simm[`XLEN-3:0], 2'b00};

    // Word index of rs + offset.
    assign mem_addr = rs_data + simm;
    assign ls_go_o  = take_o && is_mem;
    assign ls_req_o = '{we: (opcode == `OP_SW), addr: {2'b00, mem_addr[`XLEN-1:2]},
                        wdata: rt_data};

    always_comb begin
        if (busy_q) begin
            ret_rec = pend_q;
            if (pend_q.wen)
                ret_rec.wdata = ls_rdata_i;
            retire = ls_done_i;
        end else begin
            ret_rec = cur_rec;
            if (cur_rec.wen)
                ret_rec.wdata = alu_res;
            retire = take_o && !is_mem;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy_q     <= 1'b0;
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= retire;
            if (ls_go_o)
                busy_q <= 1'b1;
            else if (ls_done_i)
                busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ls_go_o)
            pend_q <= cur_rec;
        if (retire)
            wb_q <= ret_rec;
    end

    assign wb_o       = wb_q;
    assign wb_valid_o = wb_valid_q;

endmodule

/* hdl/load_store_unit.sv */
/* One word load or store at a time. The request goes out the cycle after
   ls_go and is never refused by the arbiter. */
`timescale 1ns/1ps
`include "mips_defs.svh"

module load_store_unit
    import mips_pkg::*;
(
    input  logic             clk,
    input  logic             rst_i,
    input  logic             ls_go_i,
    input  ls_req_t          ls_req_i,
    output mem_req_t         bus_req_o,
    input  logic             bus_rvalid_i,
    input  logic [`XLEN-1:0] bus_rdata_i,
    output logic             ls_done_o,
    output logic [`XLEN-1:0] ls_rdata_o
);

    ls_req_t req_q;
    logic    act_q;

    always_ff @(posedge clk) begin
        if (rst_i)
            act_q <= 1'b0;
        else
            act_q <= ls_go_i;  // Single-cycle bus strobe.
    end

    always_ff @(posedge clk) begin
        if (ls_go_i)
            req_q <= ls_req_i;
    end

    assign bus_req_o = '{en: act_q, we: req_q.we, addr: req_q.addr, wdata: req_q.wdata};

    // Stores finish on the write cycle, loads when data returns.
    assign ls_done_o  = (act_q && req_q.we) || bus_rvalid_i;
    assign ls_rdata_o = bus_rdata_i;

endmodule

/* hdl/mips_core_top.sv */
/* MIPS32 subset core on one shared word bus with fixed one-cycle read latency.
   Memory must not stall. debug_valid_o marks each retired instruction. */
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_core_top
    import mips_pkg::*;
(
    input  logic             clk,
    input  logic             rst_i,
    output mem_req_t         mem_req_o,
    input  logic [`XLEN-1:0] mem_rdata_i,
    output wb_t              debug_wb_o,
    output logic             debug_valid_o
);

    mem_req_t         fetch_req;
    mem_req_t         lsu_req;
    logic             fetch_gnt;
    logic             fetch_rvalid;
    logic             lsu_rvalid;
    logic [`XLEN-1:0] rdata;
    fetch_t           inst;
    logic             inst_valid;
    logic             take;
    logic             redirect;
    logic [`XLEN-1:0] redirect_pc;
    logic             ls_go;
    ls_req_t          ls_req;
    logic             ls_done;
    logic [`XLEN-1:0] ls_rdata;

    fetch_unit u_fetch (
        .clk           (clk          ),
        .rst_i         (rst_i        ),
        .bus_req_o     (fetch_req    ),
        .bus_gnt_i     (fetch_gnt    ),
        .bus_rvalid_i  (fetch_rvalid ),
        .bus_rdata_i   (rdata        ),
        .redirect_i    (redirect     ),
        .redirect_pc_i (redirect_pc  ),
        .take_i        (take         ),
        .inst_o        (inst         ),
        .inst_valid_o  (inst_valid   )
    );

    decode_execute u_dex (
        .clk           (clk          ),
        .rst_i         (rst_i        ),
        .inst_i        (inst         ),
        .inst_valid_i  (inst_valid   ),
        .take_o        (take         ),
        .redirect_o    (redirect     ),
        .redirect_pc_o (redirect_pc  ),
        .ls_go_o       (ls_go        ),
        .ls_req_o      (ls_req       ),
        .ls_done_i     (ls_done      ),
        .ls_rdata_i    (ls_rdata     ),
        .wb_o          (debug_wb_o   ),
        .wb_valid_o    (debug_valid_o)
    );

    load_store_unit u_lsu (
        .clk           (clk          ),
        .rst_i         (rst_i        ),
        .ls_go_i       (ls_go        ),
        .ls_req_i      (ls_req       ),
        .bus_req_o     (lsu_req      ),
        .bus_rvalid_i  (lsu_rvalid   ),
        .bus_rdata_i   (rdata        ),
        .ls_done_o     (ls_done      ),
        .ls_rdata_o    (ls_rdata     )
    );

    bus_arbiter u_arb (
        .clk            (clk          ),
        .rst_i          (rst_i        ),
        .fetch_req_i    (fetch_req    ),
        .lsu_req_i      (lsu_req      ),
        .mem_req_o      (mem_req_o    ),
        .mem_rdata_i    (mem_rdata_i  ),
        .fetch_gnt_o    (fetch_gnt    ),
        .fetch_rvalid_o (fetch_rvalid ),
        .lsu_rvalid_o   (lsu_rvalid   ),
        .rdata_o        (rdata        )
    );

endmodule

/* verif/mips_properties.sv */
/* Bus checks for bus_arbiter. Assumes a memory of MEM_WORDS words that
   answers every read one cycle after the request. */
`timescale 1ns/1ps

module mips_properties
    import mips_pkg::*;
#(
    parameter int MEM_WORDS = 256  // Testbench memory size in words.
) (
    input logic     clk,
    input logic     rst_i,
    input mem_req_t fetch_req_i,
    input mem_req_t lsu_req_i,
    input mem_req_t mem_req_i,
    input logic     fetch_gnt_i,
    input logic     fetch_rvalid_i,
    input logic     lsu_rvalid_i
);

    int fail_count = 0;  // Failed assertions so far.

    // Responses follow their grant by one cycle, to that peer only.
    fetch_resp_next: assert property (@(posedge clk) disable iff (rst_i)
        fetch_gnt_i |=> fetch_rvalid_i && !lsu_rvalid_i)
    else begin
        fail_count++;
        $error("Granted fetch got no response of its own in the next cycle");
    end

    lsu_resp_next: assert property (@(posedge clk) disable iff (rst_i)
        lsu_req_i.en && !lsu_req_i.we |=> lsu_rvalid_i && !fetch_rvalid_i)
    else begin
        fail_count++;
        $error("Load got no response of its own in the next cycle");
    end

    fetch_resp_owner: assert property (@(posedge clk) disable iff (rst_i)
        fetch_rvalid_i |-> $past(fetch_gnt_i))
    else begin
        fail_count++;
        $error("Fetch response without a fetch grant in the previous cycle");
    end

    lsu_resp_owner: assert property (@(posedge clk) disable iff (rst_i)
        lsu_rvalid_i |-> $past(lsu_req_i.en && !lsu_req_i.we))
    else begin
        fail_count++;
        $error("Load response without a load in the previous cycle");
    end

    fetch_held: assert property (@(posedge clk) disable iff (rst_i)
        fetch_req_i.en && !fetch_gnt_i |=> fetch_req_i.en)
    else begin
        fail_count++;
        $error("Fetch request dropped before it was granted");
    end

    addr_in_range: assert property (@(posedge clk) disable iff (rst_i)
        mem_req_i.en |-> (mem_req_i.addr < MEM_WORDS))
    else begin
        fail_count++;
        $error("Bus address beyond the end of memory");
    end

endmodule

/* verif/tb_mips_core.sv */
/* Random program of ALU, word load/store and forward branch instructions.
   Program in words 0..127, self-loop after it, 64 data words at word 192. */
`timescale 1ns/1ps
`include "mips_defs.svh"

module tb_mips_core
    import mips_pkg::*;
();

    localparam int NUM_INSTR      = 128;
    localparam int PROLOGUE       = 8;
    localparam int MEM_WORDS      = 256;
    localparam int MEM_AW         = 8;
    localparam int DATA_BASE      = 192;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 8 + 200;
    localparam logic [31:0] LOOP_INSTR = {`OP_BEQ, 5'd0, 5'd0, 16'hFFFF};

    logic             clk = 1'b0;
    logic             rst_i;
    mem_req_t         mem_req_o;
    logic [`XLEN-1:0] mem_rdata_i;
    wb_t              debug_wb_o;
    logic             debug_valid_o;

    integer      seed;
    logic [31:0] mem [0:MEM_WORDS-1];
    logic [31:0] model_mem [0:MEM_WORDS-1];
    logic [31:0] model_regs [0:31];
    wb_t         exp_wb[$];
    int          exp_kind[$];  // Test index of each retirement.
    logic [63:0] exp_st[$];    // {word address, data}.
    int          n_ret;
    int          n_st;
    int          checks[4];
    int          errs[4];
    string       test_names[4] = '{"reset", "alu", "memory", "branch"};

    mips_core_top u_dut (
        .clk           (clk          ),
        .rst_i         (rst_i        ),
        .mem_req_o     (mem_req_o    ),
        .mem_rdata_i   (mem_rdata_i  ),
        .debug_wb_o    (debug_wb_o   ),
        .debug_valid_o (debug_valid_o)
    );

    bind bus_arbiter mips_properties u_props (
        .clk            (clk           ),
        .rst_i          (rst_i         ),
        .fetch_req_i    (fetch_req_i   ),
        .lsu_req_i      (lsu_req_i     ),
        .mem_req_i      (mem_req_o     ),
        .fetch_gnt_i    (fetch_gnt_o   ),
        .fetch_rvalid_i (fetch_rvalid_o),
        .lsu_rvalid_i   (lsu_rvalid_o  )
    );

    always #5 clk = ~clk;

    function automatic int rand_below(int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    // Register 1 is the data base and never a random operand.
    function automatic logic [4:0] pick_reg();
        int idx;
        idx = rand_below(7);
        return (idx == 0) ? 5'd0 : 5'(idx + 1);
    endfunction

    function automatic logic [31:0] fill_word(int a);
        return 32'(a) * 32'h9E37_79B1 ^ 32'h5A5A_0000;
    endfunction

    task automatic build_program();
        int         kind;
        int         max_off;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        mem[0] = {`OP_LUI, 5'd0, 5'd1, 16'h0000};
        mem[1] = {`OP_ADDIU, 5'd1, 5'd1, 16'(DATA_BASE * 4)};
        for (int r = 2; r < PROLOGUE; r++)
            mem[r] = {`OP_ADDIU, 5'd0, 5'(r), 16'($random(seed))};
        for (int i = PROLOGUE; i < NUM_INSTR; i++) begin
            rs   = pick_reg();
            rt   = pick_reg();
            rd   = pick_reg();
            kind = rand_below(11);
            case (kind)
                0: mem[i] = {`OP_RTYPE, rs, rt, rd, 5'd0, `FN_ADDU};
                1: mem[i] = {`OP_RTYPE, rs, rt, rd, 5'd0, `FN_SUBU};
                2: mem[i] = {`OP_RTYPE, rs, rt, rd, 5'd0, `FN_AND};
                3: mem[i] = {`OP_RTYPE, rs, rt, rd, 5'd0, `FN_OR};
                4: mem[i] = {`OP_RTYPE, rs, rt, rd, 5'd0, `FN_SLT};
                5: mem[i] = {`OP_ADDIU, rs, rt, 16'($random(seed))};
                6: mem[i] = {`OP_LUI, 5'd0, rt, 16'($random(seed))};
                7: mem[i] = {`OP_LW, 5'd1, rt, 16'(rand_below(64) * 4)};
                8: mem[i] = {`OP_SW, 5'd1, rt, 16'(rand_below(64) * 4)};
                default: begin
                    max_off = NUM_INSTR - 1 - i;  // Target at most the end of the program.
                    if (max_off > 8)
                        max_off = 8;
                    mem[i] = {(kind == 9) ? `OP_BEQ : `OP_BNE, rs, rt,
                              16'(rand_below(max_off + 1))};
                end
            endcase
        end
        for (int a = NUM_INSTR; a < MEM_WORDS; a++)
            mem[a] = (a < DATA_BASE) ? LOOP_INSTR : fill_word(a);
    endtask

    task automatic run_model();
        logic [31:0] pc;
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] addr;
        wb_t         rec;
        int          kind;
        for (int w = 0; w < MEM_WORDS; w++)
            model_mem[w] = mem[w];
        for (int r = 0; r < 32; r++)
            model_regs[r] = '0;
        pc = `RESET_PC;
        while (pc < NUM_INSTR * 4) begin
            instr = model_mem[pc[31:2]];
            a     = model_regs[instr[25:21]];
            b     = model_regs[instr[20:16]];
            simm  = {{16{instr[15]}}, instr[15:0]};
            addr  = (a + simm) >> 2;
            rec   = '{pc: pc, wen: 1'b1, wraddr: instr[20:16], wdata: '0};
            kind  = 1;
            pc    = pc + 32'd4;
            case (instr[31:26])
                `OP_RTYPE: begin
                    rec.wraddr = instr[15:11];
                    case (instr[5:0])
                        `FN_ADDU: rec.wdata = a + b;
                        `FN_SUBU: rec.wdata = a - b;
                        `FN_AND:  rec.wdata = a & b;
                        `FN_OR:   rec.wdata = a | b;
                        default:  rec.wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    endcase
                end
                `OP_ADDIU: rec.wdata = a + simm;
                `OP_LUI:   rec.wdata = {instr[15:0], 16'h0000};
                `OP_LW: begin
                    rec.wdata = model_mem[addr];
                    kind      = 2;
                end
                `OP_SW: begin
                    model_mem[addr] = b;
                    exp_st.push_back({addr, b});
                    rec.wen = 1'b0;
                    kind    = 2;
                end
                default: begin
                    rec.wen = 1'b0;
                    kind    = 3;
                    if ((instr[31:26] == `OP_BEQ) == (a == b))
                        pc = pc + {simm[29:0], 2'b00};
                end
            endcase
            if (rec.wen && rec.wraddr != 5'd0)
                model_regs[rec.wraddr] = rec.wdata;
            exp_wb.push_back(rec);
            exp_kind.push_back(kind);
        end
    endtask

    task automatic check_value(input int test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        checks[test]++;
        if (actual !== expected) begin
            errs[test]++;
            $display("CHECK FAILED %s %s: expected %h, actual %h",
                     test_names[test], what, expected, actual);
        end
    endtask

    task automatic report_test(input int test);
        $display("Test %s: %0d checks, %0d errors", test_names[test], checks[test], errs[test]);
    endtask

    // Memory with one-cycle read latency.
    always @(posedge clk) begin
        if (!rst_i && mem_req_o.en) begin
            if (mem_req_o.we)
                mem[mem_req_o.addr[MEM_AW-1:0]] <= mem_req_o.wdata;
            else
                mem_rdata_i <= mem[mem_req_o.addr[MEM_AW-1:0]];
        end
    end

    always @(posedge clk) begin
        if (!rst_i && debug_valid_o && n_ret < exp_wb.size()) begin
            check_value(exp_kind[n_ret], "pc", exp_wb[n_ret].pc, debug_wb_o.pc);
            check_value(exp_kind[n_ret], "wen", exp_wb[n_ret].wen, debug_wb_o.wen);
            if (exp_wb[n_ret].wen)
                check_value(exp_kind[n_ret], "wraddr", exp_wb[n_ret].wraddr,
                            debug_wb_o.wraddr);
            check_value(exp_kind[n_ret], "wdata", exp_wb[n_ret].wdata, debug_wb_o.wdata);
            n_ret <= n_ret + 1;
        end
    end

    always @(posedge clk) begin
        if (!rst_i && mem_req_o.en && mem_req_o.we) begin
            if (n_st < exp_st.size()) begin
                check_value(2, "store address", exp_st[n_st][63:32], mem_req_o.addr);
                check_value(2, "store data", exp_st[n_st][31:0], mem_req_o.wdata);
            end else begin
                errs[2]++;
                $display("Unexpected store to word %0d after the last expected store",
                         mem_req_o.addr);
            end
            n_st <= n_st + 1;
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * 10);
        $display("Timeout: %0d of %0d instructions retired after %0d cycles",
                 n_ret, exp_wb.size(), TIMEOUT_CYCLES);
        $display("Regression failed");
        $finish;
    end

    initial begin
        int total_checks;
        int total_errs;
        seed        = 79472;
        rst_i       = 1'b1;
        mem_rdata_i = '0;
        n_ret       = 0;
        n_st        = 0;
        build_program();
        run_model();
        @(posedge clk);
        repeat (2) begin
            @(posedge clk);
            check_value(0, "debug_valid_o in reset", 32'd0, debug_valid_o);
        end
        rst_i <= 1'b0;
        @(posedge clk);
        check_value(0, "first request en", 32'd1, mem_req_o.en);
        check_value(0, "first request we", 32'd0, mem_req_o.we);
        check_value(0, "first request address", `RESET_PC >> 2, mem_req_o.addr);
        report_test(0);
        while (n_ret < exp_wb.size())
            @(posedge clk);
        check_value(2, "store count", exp_st.size(), n_st);
        total_checks = 0;
        total_errs   = u_dut.u_arb.u_props.fail_count;
        for (int t = 0; t < 4; t++) begin
            if (t > 0)
                report_test(t);
            total_checks += checks[t];
            total_errs   += errs[t];
        end
        $display("Totals: %0d instructions, %0d checks, %0d errors, %0d assertion failures",
                 n_ret, total_checks, total_errs, u_dut.u_arb.u_props.fail_count);
        if (total_errs == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

/* list.f */
+incdir+hdl
hdl/mips_pkg.sv
hdl/bus_arbiter.sv
hdl/fetch_unit.sv
hdl/reg_file.sv
hdl/decode_execute.sv
hdl/load_store_unit.sv
hdl/mips_core_top.sv
verif/mips_properties.sv
verif/tb_mips_core.sv
